// ==== Makefile ====
# Verilator build and run for the FIR filter testbench.
# The default target builds and runs the simulation and then checks the log.

VERILATOR    ?= verilator
TOP          := fir_tb
FILELIST     := sources.f
BUILD_DIR    := obj_dir
LOG          := sim.log
FLAGS        := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS   := --lint-only -Wall --timing --timescale 1ns/100ps
PASS_PATTERN := TEST RESULT: PASS
SOURCES      := $(wildcard source/*.sv source/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_PATTERN)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== source/fir_config.svh ====
// Build-time sizing for the FIR filter block.
// Include this header wherever tap count, sample or bus widths are needed.
`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

// Number of filter taps, and so the number of coefficient writes per load.
`define FIR_TAPS 10

// Width of one sample and of one coefficient.
// Both are signed two's complement values.
`define FIR_DATA_WIDTH 8

// Full-precision result width.
// A product needs twice the data width, and ten taps add four guard bits.
`define FIR_ACC_WIDTH 20

// Wishbone word address width.
// Three registers are decoded, so two bits suffice.
`define FIR_WB_ADDR_WIDTH 2

// Wishbone data bus width.
`define FIR_WB_DATA_WIDTH 32

`endif

// ==== source/fir_datapath.sv ====
// Two-stage FIR datapath.
// Stage one shifts an accepted sample into the history line and registers
// the tap products; stage two adds them into the full-precision result.
// A result appears two cycles after each accepted sample.
`default_nettype none

`include "fir_config.svh"

module fir_datapath (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic sample_valid,
	input wire fir_pkg::fir_sample_t sample_data,
	input wire logic sample_ready,
	input wire logic history_clear,
	input wire fir_pkg::fir_coef_t coefs [`FIR_TAPS],
	output logic result_valid,
	output fir_pkg::fir_acc_t result_data
);

	// A product of two data-width values needs twice the width.
	localparam int prod_width = 2 * `FIR_DATA_WIDTH;

	typedef logic signed [prod_width-1:0] prod_t;

	// Handshake on the sample stream.
	logic accept;

	// Slot 0 of the history holds the newest sample.
	fir_pkg::fir_sample_t history [`FIR_TAPS];
	fir_pkg::fir_sample_t history_next [`FIR_TAPS];

	// Stage one registers.
	prod_t products [`FIR_TAPS];
	logic products_valid;

	// Adder tree output, registered in stage two.
	fir_pkg::fir_acc_t product_sum;

	assign accept = sample_valid && sample_ready;

	// Next history line.
	// An accepted sample pushes everything one slot older.
	// A clear zeroes the old samples, but a sample accepted on the same
	// edge is kept as the newest entry so its result is still produced.
	always_comb begin
		history_next[0] = accept ? sample_data : history[0];
		for (int k = 1; k < `FIR_TAPS; k++) begin
			history_next[k] = accept ? history[k - 1] : history[k];
		end
		if (history_clear) begin
			for (int k = 1; k < `FIR_TAPS; k++) begin
				history_next[k] = '0;
			end
			if (!accept) begin
				history_next[0] = '0;
			end
		end
	end

	// History line.
	// It starts from zero so samples older than reset count as zero.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				history[k] <= '0;
			end
		end else begin
			history <= history_next;
		end
	end

	// Stage one products.
	// Tap k pairs coefficient c_k with the sample k steps older than the
	// newest one, taken from the updated history line.
	always_ff @(posedge clock) begin
		if (accept) begin
			for (int k = 0; k < `FIR_TAPS; k++) begin
				products[k] <= history_next[k] * coefs[k];
			end
		end
	end

	// Stage one valid flag.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			products_valid <= 1'b0;
		end else begin
			products_valid <= accept;
		end
	end

	// Sum of the registered products.
	// Each product is sign-extended to the accumulator width first.
	always_comb begin
		product_sum = '0;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			product_sum = product_sum + fir_pkg::fir_acc_t'(products[k]);
		end
	end

	// Stage two result register.
	// Only updated when a sum is due, so the data holds between pulses.
	always_ff @(posedge clock) begin
		if (products_valid) begin
			result_data <= product_sum;
		end
	end

	// Result strobe, one cycle per accepted sample.
	// There is no back-pressure, so it always follows stage one.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= products_valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/fir_pkg.sv ====
// Shared types for the FIR filter block.
// Modules refer to these by scoped name, for example fir_pkg::fir_state_e.
`default_nettype none

`include "fir_config.svh"

package fir_pkg;

	// One input sample and one coefficient, both signed.
	typedef logic signed [`FIR_DATA_WIDTH-1:0] fir_sample_t;
	typedef logic signed [`FIR_DATA_WIDTH-1:0] fir_coef_t;

	// Full-precision filter result.
	typedef logic signed [`FIR_ACC_WIDTH-1:0] fir_acc_t;

	// Filter phases, as reported in the low two bits of the status register.
	typedef enum logic [1:0] {
		FIR_IDLE = 2'd0,
		FIR_LOAD = 2'd1,
		FIR_RUN  = 2'd2,
		FIR_STOP = 2'd3
	} fir_state_e;

	// Opcodes written to the low bits of the control register.
	typedef enum logic [1:0] {
		CMD_NONE = 2'd0,
		CMD_LOAD = 2'd1,
		CMD_STOP = 2'd2
	} fir_cmd_e;

	// Register word addresses on the Wishbone port.
	typedef enum logic [`FIR_WB_ADDR_WIDTH-1:0] {
		REG_COEF   = 2'd0,
		REG_CTRL   = 2'd1,
		REG_STATUS = 2'd2
	} fir_reg_e;

endpackage

`default_nettype wire

// ==== source/fir_top.sv ====
// Top level of the FIR filter block.
// Coefficients and commands arrive on the Wishbone port, samples on the
// valid/ready stream, and results leave as a valid pulse with data.
`default_nettype none

`include "fir_config.svh"

module fir_top (
	input wire logic clock,
	input wire logic arst_n,

	// Wishbone classic slave port.
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [`FIR_WB_ADDR_WIDTH-1:0] wb_adr,
	input wire logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_w,
	output logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,

	// Sample stream.
	input wire logic sample_valid,
	input wire fir_pkg::fir_sample_t sample_data,
	output logic sample_ready,

	// Results, without back-pressure.
	output logic result_valid,
	output fir_pkg::fir_acc_t result_data
);

	// Coefficients from the register block, c0 in slot 0.
	fir_pkg::fir_coef_t coefs [`FIR_TAPS];

	// Pulse from a load command that empties the history line.
	logic history_clear;

	// Register block and control FSM.
	fir_wb_regs i_regs (
		.clock         (clock),
		.arst_n        (arst_n),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.coefs         (coefs),
		.history_clear (history_clear),
		.sample_ready  (sample_ready)
	);

	// Filter pipeline.
	// The ready it sees is the same one the stream source sees.
	fir_datapath i_datapath (
		.clock         (clock),
		.arst_n        (arst_n),
		.sample_valid  (sample_valid),
		.sample_data   (sample_data),
		.sample_ready  (sample_ready),
		.history_clear (history_clear),
		.coefs         (coefs),
		.result_valid  (result_valid),
		.result_data   (result_data)
	);

endmodule

`default_nettype wire

// ==== source/fir_wb_regs.sv ====
// Wishbone classic register slave and control FSM of the FIR filter.
// It holds the coefficient shift register and the coefficient count,
// and it opens the sample stream only while the filter runs.
`default_nettype none

`include "fir_config.svh"

module fir_wb_regs (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic wb_cyc,
	input wire logic wb_stb,
	input wire logic wb_we,
	input wire logic [`FIR_WB_ADDR_WIDTH-1:0] wb_adr,
	input wire logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_w,
	output logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_r,
	output logic wb_ack,
	output fir_pkg::fir_coef_t coefs [`FIR_TAPS],
	output logic history_clear,
	output logic sample_ready
);

	// The status register reports the count in an eight-bit field.
	localparam int count_width = 8;

	// A new request is one that has not been acknowledged yet.
	logic access;
	logic write_coef;
	logic write_ctrl;
	fir_pkg::fir_reg_e reg_sel;
	fir_pkg::fir_cmd_e cmd;
	fir_pkg::fir_state_e state;
	logic [count_width-1:0] coef_count;
	logic [`FIR_WB_DATA_WIDTH-1:0] status_word;

	// The ack blocks a second access for the same request.
	// The master keeps cyc and stb up until it has seen the ack.
	assign access = wb_cyc && wb_stb && !wb_ack;

	// Decode the word address and the opcode field.
	assign reg_sel = fir_pkg::fir_reg_e'(wb_adr);
	assign cmd = fir_pkg::fir_cmd_e'(wb_dat_w[1:0]);

	assign write_coef = access && wb_we && (reg_sel == fir_pkg::REG_COEF);
	assign write_ctrl = access && wb_we && (reg_sel == fir_pkg::REG_CTRL);

	// A load command also wipes the sample history in the datapath.
	// It lasts one cycle because the ack follows on the next edge.
	assign history_clear = write_ctrl && (cmd == fir_pkg::CMD_LOAD);

	// Samples are taken only while the filter runs.
	assign sample_ready = (state == fir_pkg::FIR_RUN);

	// The ack is raised one cycle after cyc and stb are seen.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= access;
		end
	end

	// Status layout.
	// State in bits 1:0, coefficient count in bits 11:4, all else zero.
	always_comb begin
		status_word = '0;
		status_word[1:0] = state;
		status_word[4 +: count_width] = coef_count;
	end

	// Read data is captured on the same edge that raises the ack.
	// Anything but the status register reads as zero.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			wb_dat_r <= '0;
		end else if (access) begin
			if (!wb_we && (reg_sel == fir_pkg::REG_STATUS)) begin
				wb_dat_r <= status_word;
			end else begin
				wb_dat_r <= '0;
			end
		end
	end

	// Filter FSM and coefficient count.
	// The load command wins from any state and restarts the count.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= fir_pkg::FIR_IDLE;
			coef_count <= '0;
		end else if (history_clear) begin
			state <= fir_pkg::FIR_LOAD;
			coef_count <= '0;
		end else if (write_ctrl && (cmd == fir_pkg::CMD_STOP)) begin
			// Stop is only honoured from the run phase.
			if (state == fir_pkg::FIR_RUN) begin
				state <= fir_pkg::FIR_STOP;
			end
		end else if (write_coef && (state == fir_pkg::FIR_LOAD)) begin
			coef_count <= coef_count + count_width'(1);
			// The last tap written starts filtering on its own.
			if (coef_count == count_width'(`FIR_TAPS - 1)) begin
				state <= fir_pkg::FIR_RUN;
			end
		end
	end

	// Coefficient shift register.
	// New values enter at the top and move down one slot per write,
	// so after a full load slot 0 holds the first value written, c0.
	// Writes outside the load phase are acknowledged and dropped.
	always_ff @(posedge clock) begin
		if (write_coef && (state == fir_pkg::FIR_LOAD)) begin
			for (int k = 0; k < `FIR_TAPS - 1; k++) begin
				coefs[k] <= coefs[k + 1];
			end
			coefs[`FIR_TAPS - 1] <= fir_pkg::fir_coef_t'(wb_dat_w[`FIR_DATA_WIDTH-1:0]);
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/fir_pkg.sv
source/fir_wb_regs.sv
source/fir_datapath.sv
source/fir_top.sv
verif/fir_chk.sv
verif/fir_tb.sv

// ==== verif/fir_chk.sv ====
// Concurrent checks on the FIR block, bound into fir_top.
// They watch the Wishbone ack, the result latency and the stream ready.
`default_nettype none

module fir_chk (
	input wire logic clock,
	input wire logic arst_n,
	input wire logic wb_ack,
	input wire logic sample_valid,
	input wire logic sample_ready,
	input wire logic result_valid,
	input wire logic [1:0] state
);
	timeunit 1ns;
	timeprecision 100ps;

	// An ack lasts a single cycle and is never repeated for one request.
	ack_single: assert property (@(posedge clock) disable iff (!arst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for more than one cycle");

	// Every accepted sample gives a result two cycles later.
	result_latency: assert property (@(posedge clock) disable iff (!arst_n)
		(sample_valid && sample_ready) |-> ##2 result_valid)
		else $error("no result two cycles after an accepted sample");

	// And no result shows up without such a sample.
	result_cause: assert property (@(posedge clock) disable iff (!arst_n)
		result_valid |-> $past(sample_valid && sample_ready, 2))
		else $error("result_valid without a sample accepted two cycles before");

	// The stream is open only while the filter runs.
	ready_in_run: assert property (@(posedge clock) disable iff (!arst_n)
		sample_ready |-> (state == fir_pkg::FIR_RUN))
		else $error("sample_ready high outside the run state");

endmodule

// The state is taken from the register block inside the top level.
bind fir_top fir_chk i_chk (
	.clock        (clock),
	.arst_n       (arst_n),
	.wb_ack       (wb_ack),
	.sample_valid (sample_valid),
	.sample_ready (sample_ready),
	.result_valid (result_valid),
	.state        (i_regs.state)
);

`default_nettype wire

// ==== verif/fir_tb.sv ====
// Testbench for the FIR filter block.
// Loads coefficients over Wishbone, streams random samples and compares
// every result with a software model of the filter sum.
`default_nettype none

`include "fir_config.svh"

module fir_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Worst case is well under 1000 cycles: about 40 register accesses of
	// three cycles, 230 back-to-back samples and 150 samples with gaps.
	localparam int timeout_cycles = 3000;
	localparam int burst_len = 200;
	localparam int gapped_len = 150;
	localparam int gap_percent = 40;
	localparam int reload_len = 30;

	logic clock = 1'b0;
	logic arst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`FIR_WB_ADDR_WIDTH-1:0] wb_adr;
	logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_w;
	logic [`FIR_WB_DATA_WIDTH-1:0] wb_dat_r;
	logic wb_ack;
	logic sample_valid;
	fir_pkg::fir_sample_t sample_data;
	logic sample_ready;
	logic result_valid;
	fir_pkg::fir_acc_t result_data;

	integer seed = 51995;
	int cycle_count = 0;

	// Software model of the filter: c0 first, newest sample first.
	fir_pkg::fir_coef_t coef_model [$];
	fir_pkg::fir_sample_t hist_model [$];
	fir_pkg::fir_acc_t expected_q [$];
	int accept_cycle_q [$];

	fir_top i_dut (
		.clock        (clock),
		.arst_n       (arst_n),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_w     (wb_dat_w),
		.wb_dat_r     (wb_dat_r),
		.wb_ack       (wb_ack),
		.sample_valid (sample_valid),
		.sample_data  (sample_data),
		.sample_ready (sample_ready),
		.result_valid (result_valid),
		.result_data  (result_data)
	);

	always #50 clock = ~clock;

	// Sum of c_k times x[n-k] over all taps, at full precision.
	function automatic fir_pkg::fir_acc_t expected_output(
		input fir_pkg::fir_coef_t coef_list [$],
		input fir_pkg::fir_sample_t hist_list [$]
	);
		longint sum;
		sum = 0;
		for (int k = 0; k < `FIR_TAPS; k++) begin
			sum += longint'(coef_list[k]) * longint'(hist_list[k]);
		end
		return sum[`FIR_ACC_WIDTH-1:0];
	endfunction

	task automatic fail_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_equal(input string name, input int got, input int want);
		assert (got == want) else begin
			$display("FAILED at time %0t: %s is %0d, expected %0d", $time, name, got, want);
			fail_run();
		end
	endtask

	// History after reset or a load is all zeros.
	task automatic clear_model();
		coef_model.delete();
		hist_model.delete();
		for (int k = 0; k < `FIR_TAPS; k++) begin
			hist_model.push_back('0);
		end
	endtask

	// One Wishbone classic cycle; cyc and stb stay up until the ack.
	task automatic wb_access(
		input logic we,
		input fir_pkg::fir_reg_e addr,
		input logic [`FIR_WB_DATA_WIDTH-1:0] data,
		output logic [`FIR_WB_DATA_WIDTH-1:0] rdata
	);
		@(posedge clock);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= addr;
		wb_dat_w <= data;
		@(negedge clock);
		while (!wb_ack) begin
			@(negedge clock);
		end
		rdata = wb_dat_r;
		@(posedge clock);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic write_reg(input fir_pkg::fir_reg_e addr, input logic [31:0] data);
		logic [`FIR_WB_DATA_WIDTH-1:0] unused;
		wb_access(1'b1, addr, data, unused);
	endtask

	task automatic send_command(input fir_pkg::fir_cmd_e cmd);
		logic [`FIR_WB_DATA_WIDTH-1:0] data;
		data = '0;
		data[1:0] = cmd;
		write_reg(fir_pkg::REG_CTRL, data);
		// A load also empties the filter history.
		if (cmd == fir_pkg::CMD_LOAD) begin
			clear_model();
		end
	endtask

	task automatic check_status(input fir_pkg::fir_state_e want_state, input int want_count);
		logic [`FIR_WB_DATA_WIDTH-1:0] status;
		wb_access(1'b0, fir_pkg::REG_STATUS, '0, status);
		check_equal("status state field", int'(status[1:0]), int'(want_state));
		check_equal("status count field", int'(status[11:4]), want_count);
	endtask

	// Random words with random upper bits, only the low byte is a coefficient.
	task automatic load_coefficients(input int count);
		logic [31:0] word;
		for (int n = 0; n < count; n++) begin
			word = $random(seed);
			write_reg(fir_pkg::REG_COEF, word);
			coef_model.push_back(word[`FIR_DATA_WIDTH-1:0]);
		end
	endtask

	// Sends count samples; with a nonzero gap chance valid drops at random.
	task automatic stream_samples(input int count, input int gap_chance);
		int sent;
		logic [31:0] word;
		sent = 0;
		while (sent < count) begin
			@(posedge clock);
			word = $random(seed);
			sample_data <= word[`FIR_DATA_WIDTH-1:0];
			if (gap_chance > 0 && ({$random(seed)} % 100) < gap_chance) begin
				sample_valid <= 1'b0;
			end else begin
				sample_valid <= 1'b1;
				@(negedge clock);
				if (sample_ready) begin
					sent++;
				end
			end
		end
		@(posedge clock);
		sample_valid <= 1'b0;
	endtask

	// Waits until every accepted sample has its result, then a short quiet
	// window in which a stray result would be caught.
	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
	endtask

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("ERROR at time %0t: timeout after %0d cycles", $time, cycle_count);
			fail_run();
		end
	end

	// Outputs are sampled on the falling edge, half a cycle from any change.
	// Results are compared first, then the sample about to be taken on the
	// next rising edge updates the model.
	always @(negedge clock) begin
		fir_pkg::fir_acc_t want;
		int when;
		if (arst_n && result_valid) begin
			assert (expected_q.size() > 0) else begin
				$display("ERROR at time %0t: result_valid with no sample accepted", $time);
				fail_run();
			end
			want = expected_q.pop_front();
			when = accept_cycle_q.pop_front();
			check_equal("result_data", int'(result_data), int'(want));
			check_equal("result latency", cycle_count - when, 2);
		end
		if (arst_n && sample_valid && sample_ready) begin
			hist_model.push_front(sample_data);
			void'(hist_model.pop_back());
			expected_q.push_back(expected_output(coef_model, hist_model));
			accept_cycle_q.push_back(cycle_count);
		end
	end

	initial begin
		logic [31:0] word;
		arst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		sample_valid = 1'b0;
		sample_data = '0;
		clear_model();
		repeat (8) @(posedge clock);
		arst_n <= 1'b1;

		// Quiet outputs and the idle state straight after reset.
		@(negedge clock);
		check_equal("sample_ready", int'(sample_ready), 0);
		check_equal("result_valid", int'(result_valid), 0);
		check_equal("wb_ack", int'(wb_ack), 0);
		check_status(fir_pkg::FIR_IDLE, 0);

		// Load in two halves and look at the status in between.
		send_command(fir_pkg::CMD_LOAD);
		load_coefficients(5);
		check_status(fir_pkg::FIR_LOAD, 5);
		load_coefficients(`FIR_TAPS - 5);
		check_status(fir_pkg::FIR_RUN, `FIR_TAPS);

		// Back-to-back samples.
		stream_samples(burst_len, 0);
		wait_drain();

		// A coefficient write outside loading is dropped. The count stays
		// put and the gapped stream below still runs on the loaded set.
		write_reg(fir_pkg::REG_COEF, 32'h0000_005a);
		check_status(fir_pkg::FIR_RUN, `FIR_TAPS);

		// Samples with random gaps in valid.
		stream_samples(gapped_len, gap_percent);
		wait_drain();

		// Stop closes the stream, offered samples are not taken.
		send_command(fir_pkg::CMD_STOP);
		for (int n = 0; n < 20; n++) begin
			@(posedge clock);
			word = $random(seed);
			sample_valid <= 1'b1;
			sample_data <= word[`FIR_DATA_WIDTH-1:0];
			@(negedge clock);
			check_equal("sample_ready", int'(sample_ready), 0);
		end
		@(posedge clock);
		sample_valid <= 1'b0;
		wait_drain();
		check_status(fir_pkg::FIR_STOP, `FIR_TAPS);

		// Reload while the history still holds old samples.
		send_command(fir_pkg::CMD_LOAD);
		check_status(fir_pkg::FIR_LOAD, 0);
		load_coefficients(`FIR_TAPS);
		check_status(fir_pkg::FIR_RUN, `FIR_TAPS);
		stream_samples(reload_len, 0);
		wait_drain();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire
